// ==== Makefile ====
# Verilator build and run of the emesh memory node testbench
TOP := tb_emesh
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/emesh_config.svh ====
`ifndef EMESH_CONFIG_SVH
`define EMESH_CONFIG_SVH

// ##########################################################
// Emesh field widths
// ##########################################################
`define EMESH_AW 32                   // Address width
`define EMESH_DW 32                   // Data width
`define EMESH_CTRL_W 5                // ctrlmode width

// ##########################################################
// Memory and link sizing
// ##########################################################
`define MEM_ADDR_BITS 8               // Word index, 256 words
`define LINK_TRAIN_CYCLES 16          // Training interval in clk cycles

`endif

// ==== hdl/emesh_ingress.sv ====
`timescale 1ns/10ps
`default_nettype none

module emesh_ingress (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    access_in,     // Packet strobe from mesh
   input  emesh_pkg::emesh_packet_t packet_in,
   input  logic                    link_ready,    // Link FSM in ACTIVE
   input  logic                    mem_stall,     // Memory cannot take req
   output logic                    wait_out,      // Back-pressure to mesh
   output logic                    req_valid,
   output emesh_pkg::mem_req_t     req
);

   logic accept;                      // Packet taken this edge

   // ##########################################################
   // Handshake
   // ##########################################################
   // Refuse until link is up, or while our held request is stuck
   assign wait_out = ~link_ready | (req_valid & mem_stall);
   assign accept   = access_in & ~wait_out;

   // Request valid flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_valid <= 1'b0;
      end else if (accept) begin
         req_valid <= 1'b1;           // New request replaces consumed one
      end else if (!mem_stall) begin
         req_valid <= 1'b0;           // Memory took it
      end
   end

   // ##########################################################
   // Request payload
   // ##########################################################
   // Only loads on accept, so it holds under stall
   always_ff @(posedge clk) begin
      if (accept) begin
         req.write    <= packet_in.write;
         req.index    <= emesh_pkg::mem_index_t'(packet_in.dstaddr >> 2); // Drop byte offset
         req.data     <= packet_in.data;
         req.ret_addr <= packet_in.srcaddr;       // Reads reply here
      end
   end

   // datamode and ctrlmode are not forwarded, all accesses are words

endmodule

`default_nettype wire

// ==== hdl/emesh_link_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module emesh_link_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic train_done,           // From link_timer
   output logic train_start,          // One-cycle load pulse
   output logic link_ready            // Also dut_active at top
);

   emesh_pkg::link_state_t state;
   emesh_pkg::link_state_t next_state;

   // ##########################################################
   // State register
   // ##########################################################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= emesh_pkg::LINK_RESET;
         link_ready <= 1'b0;
      end else begin
         state      <= next_state;
         link_ready <= (next_state == emesh_pkg::LINK_ACTIVE); // Registered, ACTIVE only
      end
   end

   // ##########################################################
   // Next state
   // ##########################################################
   always_comb begin
      next_state = state;
      case (state)
         emesh_pkg::LINK_RESET: begin
            next_state = emesh_pkg::LINK_TRAIN;    // Leave one cycle after reset
         end
         emesh_pkg::LINK_TRAIN: begin
            if (train_done) begin
               next_state = emesh_pkg::LINK_ACTIVE; // Training interval over
            end
         end
         emesh_pkg::LINK_ACTIVE: begin
            next_state = emesh_pkg::LINK_ACTIVE;   // Stays up
         end
         default: begin
            next_state = emesh_pkg::LINK_RESET;    // Recover from bad encoding
         end
      endcase
   end

   // Only cycle spent in RESET, so exactly one pulse
   assign train_start = (state == emesh_pkg::LINK_RESET);

endmodule

`default_nettype wire

// ==== hdl/emesh_mem_node.sv ====
`timescale 1ns/10ps
`default_nettype none

module emesh_mem_node (
   input  logic                     clk,
   input  logic                     rst_n,
   // ##########################################################
   // Emesh request side
   // ##########################################################
   input  logic                     access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                     wait_out,
   // ##########################################################
   // Emesh response side
   // ##########################################################
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                     wait_in,
   output logic                     dut_active     // Link trained and up
);

   logic                train_start;   // Controller to timer
   logic                train_done;    // Timer to controller
   logic                link_ready;    // Gates ingress
   logic                req_valid;     // Ingress to memory
   emesh_pkg::mem_req_t req;
   logic                mem_stall;     // Memory to ingress

   assign dut_active = link_ready;

   // Link bring-up
   link_timer u_link_timer (
      .clk         (clk),
      .rst_n       (rst_n),
      .train_start (train_start),
      .train_done  (train_done)
   );

   emesh_link_ctrl u_link_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .train_done  (train_done),
      .train_start (train_start),
      .link_ready  (link_ready)
   );

   // Packet to request
   emesh_ingress u_ingress (
      .clk         (clk),
      .rst_n       (rst_n),
      .access_in   (access_in),
      .packet_in   (packet_in),
      .link_ready  (link_ready),
      .mem_stall   (mem_stall),
      .wait_out    (wait_out),
      .req_valid   (req_valid),
      .req         (req)
   );

   // Storage and read responses
   emesh_memory u_memory (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req         (req),
      .wait_in     (wait_in),
      .mem_stall   (mem_stall),
      .access_out  (access_out),
      .packet_out  (packet_out)
   );

endmodule

`default_nettype wire

// ==== hdl/emesh_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module emesh_memory (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req_valid,   // Request from ingress
   input  emesh_pkg::mem_req_t      req,
   input  logic                     wait_in,     // Back-pressure on responses
   output logic                     mem_stall,   // Held response refused
   output logic                     access_out,  // Response strobe
   output emesh_pkg::emesh_packet_t packet_out   // Read response
);

   localparam int unsigned MEM_WORDS = 2 ** $bits(emesh_pkg::mem_index_t);

   emesh_pkg::data_t       mem_array [MEM_WORDS];  // Word storage
   logic [MEM_WORDS-1:0]   word_valid;             // Word written since reset
   logic                   consume;                // Request executed this edge
   emesh_pkg::data_t       rd_word;                // Read data, zero if unwritten

   // ##########################################################
   // Flow control
   // ##########################################################
   assign mem_stall = access_out & wait_in;        // Response stuck, hold everything
   assign consume   = req_valid & ~mem_stall;

   // Unwritten words read back as zero
   assign rd_word = word_valid[req.index] ? mem_array[req.index] : '0;

   // ##########################################################
   // Storage
   // ##########################################################
   always_ff @(posedge clk) begin
      if (consume && req.write) begin
         mem_array[req.index] <= req.data;         // Full word store
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         word_valid <= '0;                         // Memory reads as cleared
      end else if (consume && req.write) begin
         word_valid[req.index] <= 1'b1;
      end
   end

   // ##########################################################
   // Response register
   // ##########################################################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         access_out <= 1'b0;
      end else if (consume && !req.write) begin
         access_out <= 1'b1;                       // New read response
      end else if (!wait_in) begin
         access_out <= 1'b0;                       // Transferred, or nothing pending
      end
   end

   // Payload loads only on a read, stable while stalled
   always_ff @(posedge clk) begin
      if (consume && !req.write) begin
         packet_out.write    <= 1'b1;              // Responses travel as writes
         packet_out.datamode <= emesh_pkg::DATAMODE_WORD;
         packet_out.ctrlmode <= '0;
         packet_out.dstaddr  <= req.ret_addr;      // Back to requester
         packet_out.data     <= rd_word;
         packet_out.srcaddr  <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/emesh_pkg.sv ====
`default_nettype none

`include "emesh_config.svh"

package emesh_pkg;

   // ##########################################################
   // Width types
   // ##########################################################
   typedef logic [`EMESH_AW-1:0]     addr_t;        // Emesh byte address
   typedef logic [`EMESH_DW-1:0]     data_t;        // One memory word
   typedef logic [`EMESH_CTRL_W-1:0] ctrlmode_t;    // Carried, not decoded
   typedef logic [1:0]               datamode_t;    // Access size code
   typedef logic [`MEM_ADDR_BITS-1:0] mem_index_t;  // Word index above byte offset

   typedef logic [$clog2(`LINK_TRAIN_CYCLES+1)-1:0] train_count_t; // Training down-counter

   localparam datamode_t DATAMODE_WORD = 2'b10;    // 32-bit access

   // ##########################################################
   // Transaction structs
   // ##########################################################
   // 104-bit emesh packet, write flag on top
   typedef struct packed {
      logic      write;      // 1 = write / read response
      datamode_t datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;    // Target address
      data_t     data;       // Payload word
      addr_t     srcaddr;    // Return address for reads
   } emesh_packet_t;

   // Request handed from ingress to memory, 73 bits
   typedef struct packed {
      logic       write;     // Store vs. load
      mem_index_t index;     // Word select
      data_t      data;      // Store data
      addr_t      ret_addr;  // Response destination
   } mem_req_t;

   // ##########################################################
   // Link FSM states
   // ##########################################################
   typedef enum logic [1:0] {
      LINK_RESET,            // Just out of reset
      LINK_TRAIN,            // Waiting on training timer
      LINK_ACTIVE            // Traffic allowed
   } link_state_t;

endpackage

`default_nettype wire

// ==== hdl/link_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emesh_config.svh"

module link_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic train_start,          // Load pulse from link FSM
   output logic train_done            // Sticky until next load
);

   emesh_pkg::train_count_t count;    // Cycles left in training

   // Down-counter, stops at zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count      <= '0;
         train_done <= 1'b0;
      end else if (train_start) begin
         count      <= emesh_pkg::train_count_t'(`LINK_TRAIN_CYCLES); // Restart interval
         train_done <= 1'b0;                                          // Clear old result
      end else if (count != '0) begin
         count <= count - 1'b1;       // One tick per clk
         if (count == emesh_pkg::train_count_t'(1)) begin
            train_done <= 1'b1;       // Rises as count hits zero
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/emesh_pkg.sv
hdl/link_timer.sv
hdl/emesh_link_ctrl.sv
hdl/emesh_ingress.sv
hdl/emesh_memory.sv
hdl/emesh_mem_node.sv
testbench/tb_clock_gen.sv
testbench/tb_emesh.sv

// ==== testbench/emesh_stim.txt ====
# op addr(hex) data(hex) srcaddr(hex) count(dec), one transaction per count step
# W write, R read, B write/read pairs under random wait_in; count > 1 steps by a word
W 00000100 deadbeef 00000000 1
R 00000100 00000000 a0000100 1
R 00000204 00000000 a0000204 1
W 00000300 12345678 00000000 1
R 00000300 00000000 a0000300 1
W 00000300 cafef00d 00000000 1
R 00000300 00000000 a0000301 1
R 00000100 00000000 a0000102 1
R 00000300 00000000 a0000103 1
W 00000010 11223344 00000000 1
R 00000013 00000000 a0000013 1
R 00000011 00000000 a0000011 1
W 00000080 00000000 00000000 8
R 00000080 00000000 b0000080 8
B 00000200 00000000 c0000200 12
R 00000200 00000000 d0000200 12
B 00000080 00000000 c0000080 6
R 000003fc 00000000 e00003fc 1

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   localparam time HALF_PERIOD = 2ns;   // 4 ns clock
   localparam int  RESET_CYCLES = 5;    // Reset length in clk cycles

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Reset released just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_emesh.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emesh_config.svh"

module tb_emesh;

   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32+x^22+x^2+x+1
   localparam logic [31:0] LFSR_SEED = 32'd66;
   localparam string       STIM_FILE = "testbench/emesh_stim.txt";

   logic                     clk;
   logic                     rst_n;
   logic                     access_in;
   emesh_pkg::emesh_packet_t packet_in;
   logic                     wait_in = 1'b0;          // Response back-pressure
   logic                     wait_out;
   logic                     access_out;
   emesh_pkg::emesh_packet_t packet_out;
   logic                     dut_active;

   // Stimulus table, one entry per file line
   logic [7:0]               stim_op   [$];
   emesh_pkg::addr_t         stim_addr [$];
   emesh_pkg::data_t         stim_data [$];
   emesh_pkg::addr_t         stim_src  [$];
   int                       stim_cnt  [$];

   emesh_pkg::data_t         ref_mem [emesh_pkg::mem_index_t];  // Written words only
   emesh_pkg::emesh_packet_t exp_q [$];                         // Responses still due

   logic [31:0]              data_lfsr;
   logic [31:0]              wait_lfsr = LFSR_SEED;  // Own stream for wait_in
   logic                     random_wait;            // B section running
   logic                     link_seen = 1'b0;       // dut_active has risen
   logic                     held_valid = 1'b0;      // Response stalled last cycle
   emesh_pkg::emesh_packet_t held_packet;
   int                       cycle_count = 0;
   int                       cycle_limit;

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   emesh_mem_node uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .dut_active (dut_active)
   );

   // ##########################################################
   // Helpers
   // ##########################################################
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);   // Galois shift
   endfunction

   // One LFSR step per data bit
   task automatic draw_data(output emesh_pkg::data_t value);
      value = '0;
      for (int i = 0; i < $bits(emesh_pkg::data_t); i++) begin
         value     = {value[$bits(emesh_pkg::data_t)-2:0], data_lfsr[0]};
         data_lfsr = lfsr_step(data_lfsr);
      end
   endtask

   // Word select, byte offset dropped
   function automatic emesh_pkg::mem_index_t word_index(input emesh_pkg::addr_t addr);
      return addr[`MEM_ADDR_BITS+1:2];
   endfunction

   function automatic emesh_pkg::emesh_packet_t make_packet(input logic             write,
                                                            input emesh_pkg::addr_t dst,
                                                            input emesh_pkg::data_t data,
                                                            input emesh_pkg::addr_t src);
      emesh_pkg::emesh_packet_t pkt;
      pkt.write    = write;
      pkt.datamode = 2'b10;              // Word access
      pkt.ctrlmode = '0;
      pkt.dstaddr  = dst;
      pkt.data     = data;
      pkt.srcaddr  = src;
      return pkt;
   endfunction

   // Read response as the node should send it
   function automatic emesh_pkg::emesh_packet_t expected_response(
         input emesh_pkg::emesh_packet_t req);
      emesh_pkg::emesh_packet_t rsp;
      emesh_pkg::mem_index_t    idx;
      idx          = word_index(req.dstaddr);
      rsp.write    = 1'b1;                                   // Responses go out as writes
      rsp.datamode = 2'b10;
      rsp.ctrlmode = '0;
      rsp.dstaddr  = req.srcaddr;                            // Back to requester
      rsp.data     = ref_mem.exists(idx) ? ref_mem[idx] : '0; // Cleared at reset
      rsp.srcaddr  = '0;
      return rsp;
   endfunction

   // ##########################################################
   // Checks
   // ##########################################################
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_packet(input string                    name,
                               input emesh_pkg::emesh_packet_t expected,
                               input emesh_pkg::emesh_packet_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
      end
   endtask

   // ##########################################################
   // Stimulus file and driver
   // ##########################################################
   task automatic read_stimulus();
      int               fd;
      int               n;
      string            line;
      logic [7:0]       op;
      emesh_pkg::addr_t addr;
      emesh_pkg::data_t data;
      emesh_pkg::addr_t src;
      int               count;
      cycle_limit = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         stop_on_error("Could not open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // Skip comments
               n = $sscanf(line, "%c %h %h %h %d", op, addr, data, src, count);
               if (n != 5) begin
                  stop_on_error("A line of the stimulus file could not be parsed");
               end else begin
                  stim_op.push_back(op);
                  stim_addr.push_back(addr);
                  stim_data.push_back(data);
                  stim_src.push_back(src);
                  stim_cnt.push_back(count);
                  cycle_limit = cycle_limit + count * 8 * ((op == "B") ? 2 : 1);
               end
            end
         end
         $fclose(fd);
         cycle_limit = cycle_limit + `LINK_TRAIN_CYCLES + 40;   // Reset and drain margin
      end
   endtask

   // Called just after an edge, returns just after the accept edge
   task automatic send_packet(input emesh_pkg::emesh_packet_t pkt);
      access_in = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      while (wait_out) begin
         @(negedge clk);                  // Refused, keep offering
      end
      if (pkt.write) begin
         ref_mem[word_index(pkt.dstaddr)] = pkt.data;
      end else begin
         exp_q.push_back(expected_response(pkt));
      end
      @(posedge clk);
      #1;
      access_in = 1'b0;
   endtask

   task automatic run_line(input int n);
      emesh_pkg::data_t data;
      emesh_pkg::addr_t addr;
      if (stim_op[n] == "B") begin
         random_wait = 1'b1;
      end
      for (int i = 0; i < stim_cnt[n]; i++) begin
         addr = stim_addr[n] + emesh_pkg::addr_t'(4 * i);   // Word stride
         case (stim_op[n])
            "W": begin
               data = stim_data[n];
               if (stim_cnt[n] > 1) begin
                  draw_data(data);
                  data = data ^ addr;        // Fill word
               end
               send_packet(make_packet(1'b1, addr, data, '0));
            end
            "R": begin
               send_packet(make_packet(1'b0, addr, stim_data[n],
                                       stim_src[n] + emesh_pkg::addr_t'(i)));
            end
            "B": begin
               draw_data(data);
               send_packet(make_packet(1'b1, addr, data, '0));
               send_packet(make_packet(1'b0, addr, '0, stim_src[n] + emesh_pkg::addr_t'(i)));
            end
            default: begin
               stop_on_error("Unknown operation in the stimulus file");
            end
         endcase
      end
      random_wait = 1'b0;
   endtask

   // ##########################################################
   // Main sequence
   // ##########################################################
   initial begin
      access_in   = 1'b0;
      packet_in   = '0;
      random_wait = 1'b0;
      data_lfsr   = LFSR_SEED;
      held_packet = '0;
      read_stimulus();
      @(posedge rst_n);
      @(negedge clk);
      check_bit("dut_active after reset", 1'b0, dut_active);
      @(posedge clk);
      #1;
      for (int n = 0; n < stim_op.size(); n++) begin
         run_line(n);
      end
      while (exp_q.size() != 0) begin
         @(posedge clk);                  // Drain responses
      end
      repeat (8) @(posedge clk);          // Catch stray responses
      $display("Test passed");
      $finish;
   end

   // Random wait_in only inside B sections
   always @(posedge clk) begin
      if (random_wait) begin
         #1;
         wait_in   = wait_lfsr[0];
         wait_lfsr = lfsr_step(wait_lfsr);
      end else begin
         #1;
         wait_in = 1'b0;
      end
   end

   // ##########################################################
   // Response monitor, mid-cycle sampling
   // ##########################################################
   always @(negedge clk) begin
      if (rst_n) begin
         if (!dut_active) begin
            check_bit("dut_active stays high", link_seen, dut_active);
            check_bit("wait_out before link up", 1'b1, wait_out);
            check_bit("access_out before link up", 1'b0, access_out);
         end
         if (held_valid) begin                                  // Stalled last cycle
            check_bit("access_out held under wait_in", 1'b1, access_out);
            check_packet("packet_out held under wait_in", held_packet, packet_out);
         end
         if (access_out && exp_q.size() == 0) begin
            stop_on_error("A response appeared with no read outstanding");
         end else if (access_out && !wait_in) begin
            check_packet("read response", exp_q[0], packet_out);   // Order kept
            void'(exp_q.pop_front());
         end
         link_seen   = link_seen | dut_active;
         held_valid  = access_out & wait_in;
         held_packet = packet_out;
      end
   end

   // Run length guard
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         stop_on_error($sformatf("Timeout after %0d cycles with %0d responses still missing",
                                 cycle_limit, exp_q.size()));
      end
   end

endmodule

`default_nettype wire
